// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// First fetch lands on 0x1c000000
`define CPU_RESET_PC   32'h1bfffffc

`define CPU_XLEN       32
`define CPU_NREGS      32

// 3R format, matched against inst[31:15]
`define CPU_OP_ADD_W   17'h00020
`define CPU_OP_SUB_W   17'h00022
`define CPU_OP_SLT     17'h00024
`define CPU_OP_SLTU    17'h00025
`define CPU_OP_NOR     17'h00028
`define CPU_OP_AND     17'h00029
`define CPU_OP_OR      17'h0002a
`define CPU_OP_XOR     17'h0002b

// Immediate shifts, ui5 sits in the rk slot
`define CPU_OP_SLLI_W  17'h00081
`define CPU_OP_SRLI_W  17'h00089
`define CPU_OP_SRAI_W  17'h00091

// 2RI12 format, inst[31:22]
`define CPU_OP_ADDI_W  10'h00a
`define CPU_OP_LD_W    10'h0a2
`define CPU_OP_ST_W    10'h0a6

// 1RI20 format, inst[31:25]
`define CPU_OP_LU12I_W 7'h0a

// 2RI16 and I26 formats, inst[31:26]
`define CPU_OP_JIRL    6'h13
`define CPU_OP_B       6'h14
`define CPU_OP_BL      6'h15
`define CPU_OP_BEQ     6'h16
`define CPU_OP_BNE     6'h17

`endif

// ==== source/cpu_pkg.sv ====
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    // offs26 is split, low half sits above the high half
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri16_t fmt_2ri16;
        fmt_1ri20_t fmt_1ri20;
        fmt_i26_t   fmt_i26;
    } inst_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src_reg_is_rd;
        logic                  gr_we;
        logic                  mem_we;
        logic                  res_from_mem;
        logic                  is_beq;
        logic                  is_bne;
        logic                  is_jump;     // b, bl and jirl
        logic                  is_jirl;
        logic [4:0]            dest;
        logic [`CPU_XLEN-1:0]  alu_imm;
        logic [`CPU_XLEN-1:0]  br_offs;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]  pc;
        logic                  rf_we;
        logic [4:0]            rf_wnum;
        logic [`CPU_XLEN-1:0]  rf_wdata;
    } trace_t;

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module inst_decoder (
    input  wire cpu_pkg::inst_t inst,
    output cpu_pkg::ctrl_t      ctrl
);

    logic        op_add_w;
    logic        op_sub_w;
    logic        op_slt;
    logic        op_sltu;
    logic        op_nor;
    logic        op_and;
    logic        op_or;
    logic        op_xor;
    logic        op_slli_w;
    logic        op_srli_w;
    logic        op_srai_w;
    logic        op_addi_w;
    logic        op_ld_w;
    logic        op_st_w;
    logic        op_jirl;
    logic        op_b;
    logic        op_bl;
    logic        op_beq;
    logic        op_bne;
    logic        op_lu12i_w;
    logic        is_reg_alu;
    logic        is_shift;
    logic [25:0] offs26;

    always_comb begin
        op_add_w   = inst.fmt_3r.opcode == `CPU_OP_ADD_W;
        op_sub_w   = inst.fmt_3r.opcode == `CPU_OP_SUB_W;
        op_slt     = inst.fmt_3r.opcode == `CPU_OP_SLT;
        op_sltu    = inst.fmt_3r.opcode == `CPU_OP_SLTU;
        op_nor     = inst.fmt_3r.opcode == `CPU_OP_NOR;
        op_and     = inst.fmt_3r.opcode == `CPU_OP_AND;
        op_or      = inst.fmt_3r.opcode == `CPU_OP_OR;
        op_xor     = inst.fmt_3r.opcode == `CPU_OP_XOR;
        op_slli_w  = inst.fmt_3r.opcode == `CPU_OP_SLLI_W;
        op_srli_w  = inst.fmt_3r.opcode == `CPU_OP_SRLI_W;
        op_srai_w  = inst.fmt_3r.opcode == `CPU_OP_SRAI_W;
        op_addi_w  = inst.fmt_2ri12.opcode == `CPU_OP_ADDI_W;
        op_ld_w    = inst.fmt_2ri12.opcode == `CPU_OP_LD_W;
        op_st_w    = inst.fmt_2ri12.opcode == `CPU_OP_ST_W;
        op_jirl    = inst.fmt_2ri16.opcode == `CPU_OP_JIRL;
        op_beq     = inst.fmt_2ri16.opcode == `CPU_OP_BEQ;
        op_bne     = inst.fmt_2ri16.opcode == `CPU_OP_BNE;
        op_b       = inst.fmt_i26.opcode == `CPU_OP_B;
        op_bl      = inst.fmt_i26.opcode == `CPU_OP_BL;
        op_lu12i_w = inst.fmt_1ri20.opcode == `CPU_OP_LU12I_W;

        is_reg_alu = op_add_w | op_sub_w | op_slt | op_sltu | op_nor | op_and | op_or | op_xor;
        is_shift   = op_slli_w | op_srli_w | op_srai_w;
        offs26     = {inst.fmt_i26.offs_hi, inst.fmt_i26.offs_lo};

        ctrl = '0;
        case (1'b1)
            op_sub_w:   ctrl.alu_op = cpu_pkg::ALU_SUB;
            op_slt:     ctrl.alu_op = cpu_pkg::ALU_SLT;
            op_sltu:    ctrl.alu_op = cpu_pkg::ALU_SLTU;
            op_and:     ctrl.alu_op = cpu_pkg::ALU_AND;
            op_nor:     ctrl.alu_op = cpu_pkg::ALU_NOR;
            op_or:      ctrl.alu_op = cpu_pkg::ALU_OR;
            op_xor:     ctrl.alu_op = cpu_pkg::ALU_XOR;
            op_slli_w:  ctrl.alu_op = cpu_pkg::ALU_SLL;
            op_srli_w:  ctrl.alu_op = cpu_pkg::ALU_SRL;
            op_srai_w:  ctrl.alu_op = cpu_pkg::ALU_SRA;
            op_lu12i_w: ctrl.alu_op = cpu_pkg::ALU_LUI;
            default:    ctrl.alu_op = cpu_pkg::ALU_ADD;   // Also address and link adds
        endcase

        ctrl.src1_is_pc    = op_jirl | op_bl;
        ctrl.src2_is_imm   = is_shift | op_addi_w | op_ld_w | op_st_w | op_lu12i_w
                             | op_jirl | op_bl;
        ctrl.src_reg_is_rd = op_beq | op_bne | op_st_w;
        ctrl.gr_we         = is_reg_alu | is_shift | op_addi_w | op_lu12i_w | op_ld_w
                             | op_jirl | op_bl;
        ctrl.mem_we        = op_st_w;
        ctrl.res_from_mem  = op_ld_w;
        ctrl.is_beq        = op_beq;
        ctrl.is_bne        = op_bne;
        ctrl.is_jump       = op_b | op_bl | op_jirl;
        ctrl.is_jirl       = op_jirl;
        ctrl.dest          = op_bl ? 5'd1 : inst.fmt_3r.rd;

        if (op_jirl || op_bl) begin
            ctrl.alu_imm = 32'd4;                  // Link value pc+4
        end else if (op_lu12i_w) begin
            ctrl.alu_imm = {inst.fmt_1ri20.si20, 12'b0};
        end else begin
            ctrl.alu_imm = {{20{inst.fmt_2ri12.si12[11]}}, inst.fmt_2ri12.si12};
        end

        if (op_b || op_bl) begin
            ctrl.br_offs = {{4{offs26[25]}}, offs26, 2'b00};
        end else begin
            ctrl.br_offs = {{14{inst.fmt_2ri16.offs16[15]}}, inst.fmt_2ri16.offs16, 2'b00};
        end

        // Opcode table must stay free of overlaps
        assert ($onehot0({op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or,
                          op_xor, op_slli_w, op_srli_w, op_srai_w, op_addi_w, op_ld_w,
                          op_st_w, op_jirl, op_b, op_bl, op_beq, op_bne, op_lu12i_w}))
            else $error("instruction %h matches more than one opcode", inst);
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
    input  wire logic                         clk,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] raddr1,
    output logic [`CPU_XLEN-1:0]               rdata1,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]               rdata2,
    input  wire logic                         we,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] waddr,
    input  wire logic [`CPU_XLEN-1:0]          wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin   // r0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module alu (
    input  wire cpu_pkg::alu_op_t      op,
    input  wire logic [`CPU_XLEN-1:0]  src1,
    input  wire logic [`CPU_XLEN-1:0]  src2,
    output logic [`CPU_XLEN-1:0]       result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = src1 + src2;
            cpu_pkg::ALU_SUB:  result = src1 - src2;
            cpu_pkg::ALU_SLT:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            cpu_pkg::ALU_SLTU: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            cpu_pkg::ALU_AND:  result = src1 & src2;
            cpu_pkg::ALU_NOR:  result = ~(src1 | src2);
            cpu_pkg::ALU_OR:   result = src1 | src2;
            cpu_pkg::ALU_XOR:  result = src1 ^ src2;
            cpu_pkg::ALU_SLL:  result = src1 << shamt;
            cpu_pkg::ALU_SRL:  result = src1 >> shamt;
            cpu_pkg::ALU_SRA:  result = $signed(src1) >>> shamt;   // Sign fill
            cpu_pkg::ALU_LUI:  result = src2;   // Already shifted by the decoder
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_unit (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire cpu_pkg::ctrl_t        ctrl,
    input  wire logic [`CPU_XLEN-1:0]  rj_value,
    input  wire logic [`CPU_XLEN-1:0]  rkd_value,
    output logic [`CPU_XLEN-1:0]       pc,
    output logic                       valid
);

    localparam logic [`CPU_XLEN-1:0] PC_STEP = 4;

    logic                 operands_eq;
    logic                 branch_taken;
    logic [`CPU_XLEN-1:0] branch_base;
    logic [`CPU_XLEN-1:0] branch_target;
    logic [`CPU_XLEN-1:0] next_pc;

    assign operands_eq   = rj_value == rkd_value;
    assign branch_taken  = valid && ((ctrl.is_beq && operands_eq)
                                  || (ctrl.is_bne && !operands_eq)
                                  || ctrl.is_jump);
    assign branch_base   = ctrl.is_jirl ? rj_value : pc;   // jirl is register relative
    assign branch_target = branch_base + ctrl.br_offs;
    assign next_pc       = branch_taken ? branch_target : pc + PC_STEP;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `CPU_RESET_PC;
            valid <= 1'b0;
        end else begin
            pc    <= next_pc;
            valid <= 1'b1;
        end
    end

    // Covers decoder offsets and jirl base registers together
    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        valid |-> pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

`default_nettype wire

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_core (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output logic [`CPU_XLEN-1:0]       inst_addr,
    input  wire logic [`CPU_XLEN-1:0]  inst_rdata,
    output logic                       data_we,
    output logic [`CPU_XLEN-1:0]       data_addr,
    output logic [`CPU_XLEN-1:0]       data_wdata,
    input  wire logic [`CPU_XLEN-1:0]  data_rdata,
    output cpu_pkg::trace_t            trace
);

    cpu_pkg::inst_t       inst;
    cpu_pkg::ctrl_t       ctrl;
    logic [`CPU_XLEN-1:0] pc;
    logic                 valid;
    logic [4:0]           rf_raddr2;
    logic [`CPU_XLEN-1:0] rj_value;
    logic [`CPU_XLEN-1:0] rkd_value;
    logic [`CPU_XLEN-1:0] alu_src1;
    logic [`CPU_XLEN-1:0] alu_src2;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 rf_we;
    logic [`CPU_XLEN-1:0] rf_wdata;

    assign inst_addr = pc;
    assign inst      = inst_rdata;

    inst_decoder i_inst_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    // Stores and branches read rd on port 2
    assign rf_raddr2 = ctrl.src_reg_is_rd ? inst.fmt_3r.rd : inst.fmt_3r.rk;

    reg_file i_reg_file (
        .clk    (clk),
        .raddr1 (inst.fmt_3r.rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (ctrl.dest),
        .wdata  (rf_wdata)
    );

    assign alu_src1 = ctrl.src1_is_pc ? pc : rj_value;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.alu_imm : rkd_value;

    alu i_alu (
        .op     (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    fetch_unit i_fetch_unit (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (pc),
        .valid     (valid)
    );

    assign data_we    = ctrl.mem_we && valid;
    assign data_addr  = alu_result;
    assign data_wdata = rkd_value;

    assign rf_we    = ctrl.gr_we && valid;
    assign rf_wdata = ctrl.res_from_mem ? data_rdata : alu_result;

    assign trace = '{pc: pc, rf_we: rf_we, rf_wnum: ctrl.dest, rf_wdata: rf_wdata};

endmodule

`default_nettype wire

// ==== tb/tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_memory #(
    parameter int WORDS = 64
) (
    input  wire logic        clk,
    input  wire logic [31:0] inst_addr,
    output logic [31:0]      inst_rdata,
    input  wire logic        data_we,
    input  wire logic [31:0] data_addr,
    input  wire logic [31:0] data_wdata,
    output logic [31:0]      data_rdata
);

    localparam int          ADDR_BITS = $clog2(WORDS);
    localparam logic [31:0] ROM_BASE  = `CPU_RESET_PC + 32'd4;

    logic [31:0] rom [WORDS];   // Loaded by the testbench at time zero
    logic [31:0] ram [WORDS];
    logic [31:0] rom_offset;
    logic        rom_hit;

    assign rom_offset = inst_addr - ROM_BASE;
    assign rom_hit    = rom_offset < 32'(4 * WORDS);
    assign inst_rdata = rom_hit ? rom[rom_offset[ADDR_BITS+1:2]] : '0;   // Zero word is a no-op
    assign data_rdata = ram[data_addr[ADDR_BITS+1:2]];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ram[i[ADDR_BITS-1:0]] <= 32'hd0000000 | 32'(i * 4);   // Byte address of the word
        end
    end

    always @(posedge clk) begin
        if (data_we) begin
            ram[data_addr[ADDR_BITS+1:2]] <= data_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_cpu_core;

    localparam int          RESET_CYCLES = 10;
    localparam int          MEM_WORDS    = 64;
    localparam int          ADDR_BITS    = $clog2(MEM_WORDS);
    localparam logic [31:0] BOOT_PC      = `CPU_RESET_PC + 32'd4;
    localparam logic [11:0] ST_BASE      = 12'h040;
    localparam logic [11:0] ST_OFFS      = 12'h008;
    localparam int          CHECK_WORD   = (ST_BASE + ST_OFFS) / 4;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } wb_entry_t;

    logic            clk;
    logic            reset;
    logic [31:0]     inst_addr;
    logic [31:0]     inst_rdata;
    logic            data_we;
    logic [31:0]     data_addr;
    logic [31:0]     data_wdata;
    logic [31:0]     data_rdata;
    cpu_pkg::trace_t trace;

    logic [31:0]     prog [$];
    wb_entry_t       expected [$];
    logic [31:0]     model [32];   // Architectural registers as the program should leave them
    integer          seed        = 32'hf5f3;
    int              cycle_count = 0;
    int              cycle_limit = 0;

    cpu_core i_cpu_core (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .trace      (trace)
    );

    tb_memory #(.WORDS(MEM_WORDS)) i_tb_memory (
        .clk        (clk),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] next_pc();
        return BOOT_PC + 32'(4 * prog.size());
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic expect_write(input logic [31:0] pc, input logic [4:0] rd,
                                input logic [31:0] value);
        expected.push_back('{pc: pc, wnum: rd, wdata: value});
        if (rd != 5'd0) begin
            model[rd] = value;
        end
    endtask

    task automatic put_3r(input logic [16:0] op, input logic [4:0] rd, input logic [4:0] rj,
                          input logic [4:0] rk, input logic [31:0] value);
        expect_write(next_pc(), rd, value);
        prog.push_back({op, rk, rj, rd});
    endtask

    task automatic put_2ri12(input logic [9:0] op, input logic [4:0] rd, input logic [4:0] rj,
                             input logic [11:0] si12, input logic [31:0] value);
        expect_write(next_pc(), rd, value);
        prog.push_back({op, si12, rj, rd});
    endtask

    task automatic put_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        expect_write(next_pc(), rd, {si20, 12'h000});
        prog.push_back({`CPU_OP_LU12I_W, si20, rd});
    endtask

    // Branch over one addi that marks r17 when it runs
    task automatic put_cond_branch(input logic [5:0] op, input logic [4:0] rj,
                                   input logic [4:0] rd, input logic taken,
                                   input logic [11:0] marker);
        logic [31:0] skip_pc;
        prog.push_back({op, 16'd2, rj, rd});
        skip_pc = next_pc();
        prog.push_back({`CPU_OP_ADDI_W, marker, 5'd0, 5'd17});
        if (!taken) begin
            expect_write(skip_pc, 5'd17, {20'd0, marker});
        end
    endtask

    task automatic build_tables();
        logic [31:0] r;
        logic [31:0] call_pc;
        model = '{default: '0};
        r = $random(seed);
        put_lu12i(5'd1, {1'b0, r[30:12]});   // r1 positive
        put_2ri12(`CPU_OP_ADDI_W, 5'd1, 5'd1, r[11:0], model[1] + sext12(r[11:0]));
        r = $random(seed);
        put_lu12i(5'd2, {1'b1, r[30:12]});   // r2 negative
        put_2ri12(`CPU_OP_ADDI_W, 5'd2, 5'd2, r[11:0], model[2] + sext12(r[11:0]));
        put_3r(`CPU_OP_ADD_W, 5'd3, 5'd1, 5'd2, model[1] + model[2]);
        put_3r(`CPU_OP_SUB_W, 5'd4, 5'd1, 5'd2, model[1] - model[2]);
        put_3r(`CPU_OP_SLT, 5'd5, 5'd1, 5'd2, {31'd0, $signed(model[1]) < $signed(model[2])});
        put_3r(`CPU_OP_SLTU, 5'd6, 5'd1, 5'd2, {31'd0, model[1] < model[2]});
        put_3r(`CPU_OP_NOR, 5'd7, 5'd1, 5'd2, ~(model[1] | model[2]));
        put_3r(`CPU_OP_AND, 5'd8, 5'd1, 5'd2, model[1] & model[2]);
        put_3r(`CPU_OP_OR, 5'd9, 5'd1, 5'd2, model[1] | model[2]);
        put_3r(`CPU_OP_XOR, 5'd10, 5'd1, 5'd2, model[1] ^ model[2]);
        put_3r(`CPU_OP_SLT, 5'd23, 5'd2, 5'd1, {31'd0, $signed(model[2]) < $signed(model[1])});
        r = $random(seed);
        put_3r(`CPU_OP_SLLI_W, 5'd11, 5'd1, r[4:0], model[1] << r[4:0]);
        put_3r(`CPU_OP_SRLI_W, 5'd12, 5'd2, r[9:5], model[2] >> r[9:5]);
        put_3r(`CPU_OP_SRAI_W, 5'd13, 5'd2, r[14:10], $signed(model[2]) >>> r[14:10]);
        put_2ri12(`CPU_OP_ADDI_W, 5'd14, 5'd0, ST_BASE, {20'd0, ST_BASE});
        prog.push_back({`CPU_OP_ST_W, ST_OFFS, 5'd14, 5'd3});
        put_2ri12(`CPU_OP_LD_W, 5'd15, 5'd14, ST_OFFS, model[3]);
        r = $random(seed);
        put_2ri12(`CPU_OP_ADDI_W, 5'd0, 5'd0, r[11:0] | 12'h001, sext12(r[11:0] | 12'h001));
        put_3r(`CPU_OP_ADD_W, 5'd16, 5'd0, 5'd1, model[1]);
        put_cond_branch(`CPU_OP_BEQ, 5'd1, 5'd2, model[1] == model[2], 12'h011);
        put_cond_branch(`CPU_OP_BEQ, 5'd16, 5'd1, model[16] == model[1], 12'h012);
        put_cond_branch(`CPU_OP_BNE, 5'd1, 5'd16, model[1] != model[16], 12'h013);
        put_cond_branch(`CPU_OP_BNE, 5'd1, 5'd2, model[1] != model[2], 12'h014);
        prog.push_back(enc_i26(`CPU_OP_B, 26'd2));
        prog.push_back({`CPU_OP_ADDI_W, 12'h015, 5'd0, 5'd18});   // Never runs
        call_pc = next_pc();
        prog.push_back(enc_i26(`CPU_OP_BL, 26'd3));
        prog.push_back({`CPU_OP_ADDI_W, 12'h021, 5'd0, 5'd19});   // Return point
        prog.push_back(enc_i26(`CPU_OP_B, 26'd2));
        prog.push_back({`CPU_OP_JIRL, 16'd0, 5'd1, 5'd20});       // Called function
        expect_write(call_pc, 5'd1, call_pc + 32'd4);
        expect_write(call_pc + 32'd12, 5'd20, call_pc + 32'd16);
        expect_write(call_pc + 32'd4, 5'd19, 32'h021);
        r = $random(seed);
        put_2ri12(`CPU_OP_ADDI_W, 5'd21, 5'd19, r[11:0], model[19] + sext12(r[11:0]));
        prog.push_back(enc_i26(`CPU_OP_B, 26'd0));   // Park here
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_run($sformatf("timeout: program did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        reset <= 1'b1;
        build_tables();
        cycle_limit = 4 * expected.size() + RESET_CYCLES;
        for (int i = 0; i < MEM_WORDS; i++) begin
            i_tb_memory.rom[i[ADDR_BITS-1:0]] = (i < prog.size()) ? prog[i] : '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < expected.size(); n++) begin
            @(negedge clk);
            while (!trace.rf_we) @(negedge clk);
            assert (trace.pc == expected[n].pc && trace.rf_wnum == expected[n].wnum
                    && trace.rf_wdata == expected[n].wdata)
                else stop_run($sformatf(
                    "mismatch at %0t: write %0d got pc %h r%0d=%h, expected pc %h r%0d=%h",
                    $time, n, trace.pc, trace.rf_wnum, trace.rf_wdata,
                    expected[n].pc, expected[n].wnum, expected[n].wdata));
        end
        @(negedge clk);
        assert (i_tb_memory.ram[CHECK_WORD[ADDR_BITS-1:0]] == model[3])
            else stop_run($sformatf("mismatch at %0t: stored word %h, expected %h", $time,
                                    i_tb_memory.ram[CHECK_WORD[ADDR_BITS-1:0]], model[3]));
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
source/cpu_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/fetch_unit.sv
source/cpu_core.sv
tb/tb_memory.sv
tb/tb_cpu_core.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' compile.f) $(wildcard include/*.svh)

obj_dir/Vtb_cpu_core: compile.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_cpu_core -f compile.f

run: obj_dir/Vtb_cpu_core
	./obj_dir/Vtb_cpu_core | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
